// ==== Makefile ====
# Verilator build and run of the external harness testbench
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_ext_harness \
		-Mdir obj_dir -o tb_ext_harness
	./obj_dir/tb_ext_harness > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_ext_harness.sv ====
/*
  self-checking testbench; memory words are read only after a full-word write
  watchdog bound scales with the planned operation count
*/
`include "ext_harness_defs.svh"

module tb_ext_harness;

  timeunit 1ns;
  timeprecision 1ps;

  import ext_harness_pkg::*;

  localparam int CLK_PERIOD    = 10;
  localparam int N_WORDS       = 8;
  localparam int PLANNED_OPS   = 130;
  localparam int CYCLES_PER_OP = 4 * (`SLOW_MEM_GNT_WAIT + 1) + `SWITCH_ACK_LATENCY;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    reg_valid;
  logic    reg_write;
  addr_t   reg_addr;
  data_t   reg_wdata;
  logic    reg_ready;
  logic    reg_error;
  data_t   reg_rdata;
  logic    mem_req;
  logic    mem_we;
  be_t     mem_be;
  addr_t   mem_addr;
  data_t   mem_wdata;
  logic    mem_gnt;
  logic    mem_rvalid;
  data_t   mem_rdata;
  domain_t pwr_switch_n;
  domain_t pwr_ack_n;
  logic    iffifo_intr;
  logic    dma_slot_tx;
  logic    dma_slot_rx;

  // reference model state
  data_t   ref_mem [`SLOW_MEM_WORDS];
  data_t   exp_rdata_q [$];
  data_t   fifo_model_q [$];
  data_t   wmark_model;
  domain_t switch_model;
  integer  seed = 25;
  int      stall_cycles;

  ext_harness_top dut0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_write),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_ready_o   (reg_ready),
    .reg_error_o   (reg_error),
    .reg_rdata_o   (reg_rdata),
    .mem_req_i     (mem_req),
    .mem_we_i      (mem_we),
    .mem_be_i      (mem_be),
    .mem_addr_i    (mem_addr),
    .mem_wdata_i   (mem_wdata),
    .mem_gnt_o     (mem_gnt),
    .mem_rvalid_o  (mem_rvalid),
    .mem_rdata_o   (mem_rdata),
    .pwr_switch_n_o(pwr_switch_n),
    .pwr_ack_n_o   (pwr_ack_n),
    .iffifo_intr_o (iffifo_intr),
    .dma_slot_tx_o (dma_slot_tx),
    .dma_slot_rx_o (dma_slot_rx)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // byte-enable merge of a write into the old word
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t result;
    result = old_word;
    for (int b = 0; b < `EXT_BE_W; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // windows are aligned to their size
  function automatic logic addr_mapped(addr_t addr);
    addr_t win;
    win = addr & ~addr_t'(`PERIPH_WIN_SIZE - 1);
    return (win == addr_t'(`IFFIFO_BASE)) || (win == addr_t'(`POWER_BASE));
  endfunction

  function automatic logic expected_intr(int unsigned count, data_t wmark);
    return (wmark != '0) && (count >= wmark);
  endfunction

  function automatic addr_t fifo_addr(iffifo_reg_e r);
    return addr_t'(`IFFIFO_BASE + 4 * int'(r));
  endfunction

  function automatic addr_t pwr_addr(logic off);
    return addr_t'(`POWER_BASE + 4 * int'(off));
  endfunction

  task automatic check_data(string name, data_t expected, data_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "data mismatch on %s", name);
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "flag mismatch on %s", name);
    end
  endtask

  task automatic check_domain(string name, domain_t expected, domain_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "domain mismatch on %s", name);
    end
  endtask

  // one register access, data sampled mid-cycle before the state moves
  task automatic reg_access(input logic write, input addr_t addr, input data_t wdata,
                            output data_t rdata);
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_write <= write;
    reg_addr  <= addr;
    reg_wdata <= wdata;
    @(negedge clk);
    check_flag("reg_ready_o", 1'b1, reg_ready);
    check_flag("reg_error_o", !addr_mapped(addr), reg_error);
    rdata = reg_rdata;
    @(posedge clk);
    reg_valid <= 1'b0;
    @(negedge clk);
  endtask

  task automatic check_fifo_lines();
    data_t rdata;
    check_flag("dma_slot_tx_o", fifo_model_q.size() < `IFFIFO_DEPTH, dma_slot_tx);
    check_flag("dma_slot_rx_o", fifo_model_q.size() != 0, dma_slot_rx);
    check_flag("iffifo_intr_o", expected_intr(fifo_model_q.size(), wmark_model), iffifo_intr);
    reg_access(1'b0, fifo_addr(REG_STATUS), '0, rdata);
    check_data("REG_STATUS", data_t'(fifo_model_q.size()), rdata);
  endtask

  task automatic fifo_push(data_t value);
    data_t rd_ignored;
    reg_access(1'b1, fifo_addr(REG_PUSH), value, rd_ignored);
    // full FIFO drops the push
    if (fifo_model_q.size() < `IFFIFO_DEPTH) begin
      fifo_model_q.push_back(value);
    end
    check_fifo_lines();
  endtask

  task automatic fifo_pop();
    data_t rdata;
    data_t expected;
    reg_access(1'b0, fifo_addr(REG_POP), '0, rdata);
    if (fifo_model_q.size() == 0) begin
      expected = '0;
    end else begin
      expected = fifo_model_q.pop_front();
    end
    check_data("REG_POP", expected, rdata);
    check_fifo_lines();
  endtask

  // request held until a mid-cycle sample sees gnt, accepted on the next edge
  task automatic mem_issue(logic write, mem_idx_t idx, be_t be, data_t wdata);
    @(posedge clk);
    mem_req   <= 1'b1;
    mem_we    <= write;
    mem_be    <= be;
    mem_addr  <= addr_t'(idx) << 2;
    mem_wdata <= wdata;
    do begin
      @(negedge clk);
    end while (!mem_gnt);
    if (write) begin
      ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
      exp_rdata_q.push_back('0);
    end else begin
      exp_rdata_q.push_back(ref_mem[idx]);
    end
  endtask

  task automatic mem_idle_and_drain();
    @(posedge clk);
    mem_req <= 1'b0;
    while (exp_rdata_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic run_memory_test();
    mem_idx_t idx_list [N_WORDS];
    for (int i = 0; i < N_WORDS; i++) begin
      idx_list[i] = mem_idx_t'($random(seed));
      mem_issue(1'b1, idx_list[i], '1, $random(seed));
    end
    for (int i = 0; i < N_WORDS; i++) begin
      mem_issue(1'b1, idx_list[i], be_t'($random(seed)), $random(seed));
    end
    for (int i = 0; i < N_WORDS; i++) begin
      mem_issue(1'b0, idx_list[i], '0, '0);
    end
    mem_idle_and_drain();
  endtask

  // write, partial write, read of one word back to back
  task automatic run_stream_test();
    mem_idx_t idx;
    stall_cycles = 0;
    for (int i = 0; i < N_WORDS; i++) begin
      idx = mem_idx_t'($random(seed));
      mem_issue(1'b1, idx, '1, $random(seed));
      mem_issue(1'b1, idx, be_t'($random(seed)), $random(seed));
      mem_issue(1'b0, idx, '0, '0);
    end
    mem_idle_and_drain();
    check_flag("mem_gnt_o low while requested", 1'b1, stall_cycles > 0);
  endtask

  task automatic run_fifo_test();
    for (int i = 0; i < `IFFIFO_DEPTH + 1; i++) begin
      fifo_push($random(seed));
    end
    for (int i = 0; i < `IFFIFO_DEPTH + 1; i++) begin
      fifo_pop();
    end
  endtask

  task automatic run_watermark_test();
    data_t rdata;
    reg_access(1'b1, fifo_addr(REG_WMARK), 32'd3, rdata);
    wmark_model = 32'd3;
    reg_access(1'b0, fifo_addr(REG_WMARK), '0, rdata);
    check_data("REG_WMARK", wmark_model, rdata);
    check_fifo_lines();
    for (int i = 0; i < 4; i++) begin
      fifo_push($random(seed));
    end
    reg_access(1'b1, fifo_addr(REG_WMARK), '0, rdata);
    wmark_model = '0;
    check_fifo_lines();
    while (fifo_model_q.size() != 0) begin
      fifo_pop();
    end
  endtask

  task automatic run_power_test();
    domain_t old_value;
    domain_t new_value;
    data_t   rdata;
    for (int n = 0; n < 2; n++) begin
      old_value = switch_model;
      new_value = domain_t'($random(seed));
      if (new_value == old_value) begin
        new_value = ~old_value;
      end
      reg_access(1'b1, pwr_addr(`PWR_SWITCH_OFF), data_t'(new_value), rdata);
      switch_model = new_value;
      check_domain("pwr_switch_n_o", switch_model, pwr_switch_n);
      // ack moves exactly SWITCH_ACK_LATENCY edges after the switch
      for (int k = 0; k < `SWITCH_ACK_LATENCY; k++) begin
        check_domain("pwr_ack_n_o", old_value, pwr_ack_n);
        @(negedge clk);
      end
      check_domain("pwr_ack_n_o", switch_model, pwr_ack_n);
      reg_access(1'b0, pwr_addr(`PWR_ACK_OFF), '0, rdata);
      check_data("PWR_ACK", data_t'(switch_model), rdata);
      reg_access(1'b0, pwr_addr(`PWR_SWITCH_OFF), '0, rdata);
      check_data("PWR_SWITCH", data_t'(switch_model), rdata);
    end
  endtask

  task automatic run_unmapped_test();
    addr_t miss_addr [3];
    data_t rdata;
    miss_addr[0] = 32'h0000_2000;
    miss_addr[1] = 32'h0000_3ffc;
    miss_addr[2] = 32'hffff_fff0;
    for (int i = 0; i < 3; i++) begin
      reg_access(1'b0, miss_addr[i], '0, rdata);
      check_data("reg_rdata_o", '0, rdata);
      reg_access(1'b1, miss_addr[i], $random(seed), rdata);
      check_data("reg_rdata_o", '0, rdata);
    end
  endtask

  // back-pressure seen by the master
  always @(negedge clk) begin
    if (rst_n && mem_req && !mem_gnt) begin
      stall_cycles++;
    end
  end

  // response checker, in request order
  always @(negedge clk) begin
    data_t expected;
    if (rst_n && mem_rvalid) begin
      if (exp_rdata_q.size() == 0) begin
        $display("mem_rvalid_o rose at %0t ns with no request outstanding", $time);
        $display("TEST FAIL");
        $fatal(1, "unexpected memory response");
      end else begin
        expected = exp_rdata_q.pop_front();
        check_data("mem_rdata_o", expected, mem_rdata);
      end
    end
  end

  initial begin
    #(PLANNED_OPS * CYCLES_PER_OP * CLK_PERIOD);
    $display("run still busy after %0t ns, the DUT stopped answering", $time);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_n        <= 1'b0;
    reg_valid    <= 1'b0;
    reg_write    <= 1'b0;
    reg_addr     <= '0;
    reg_wdata    <= '0;
    mem_req      <= 1'b0;
    mem_we       <= 1'b0;
    mem_be       <= '0;
    mem_addr     <= '0;
    mem_wdata    <= '0;
    wmark_model  = '0;
    switch_model = '1;
    stall_cycles = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("mem_gnt_o", 1'b0, mem_gnt);
    check_flag("mem_rvalid_o", 1'b0, mem_rvalid);
    check_domain("pwr_switch_n_o", '1, pwr_switch_n);
    check_domain("pwr_ack_n_o", '1, pwr_ack_n);
    check_fifo_lines();
    run_memory_test();
    run_stream_test();
    run_fifo_test();
    run_watermark_test();
    run_power_test();
    run_unmapped_test();
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== common/ext_harness_defs.svh ====
/*
  widths, depths, latencies and register map of the external harness
  window bases must be aligned to PERIPH_WIN_SIZE; IFFIFO_DEPTH must be a power of two
*/
`ifndef EXT_HARNESS_DEFS_SVH
`define EXT_HARNESS_DEFS_SVH

// bus widths
`define EXT_ADDR_W 32
`define EXT_DATA_W 32
`define EXT_BE_W 4

// slow memory path, grant wait must be at least 1
`define SLOW_MEM_WORDS 1024
`define SLOW_MEM_GNT_WAIT 3
`define OBI_FIFO_DEPTH 2

// peripherals
`define IFFIFO_DEPTH 8
`define SWITCH_ACK_LATENCY 15
`define EXT_DOMAINS 4

// register windows, byte addresses
`define IFFIFO_BASE 32'h0000_0000
`define POWER_BASE 32'h0000_1000
`define PERIPH_WIN_SIZE 32'h0000_1000

// power peripheral word offsets
`define PWR_SWITCH_OFF 1'b0
`define PWR_ACK_OFF 1'b1

`endif

// ==== common/ext_harness_pkg.sv ====
/*
  types shared by the harness RTL and its testbench
  all widths follow the macros in the defs header
*/
`include "ext_harness_defs.svh"

package ext_harness_pkg;

  // bus fields
  typedef logic [`EXT_ADDR_W-1:0] addr_t;
  typedef logic [`EXT_DATA_W-1:0] data_t;
  typedef logic [`EXT_BE_W-1:0] be_t;

  // word index into the slow memory
  typedef logic [$clog2(`SLOW_MEM_WORDS)-1:0] mem_idx_t;

  // one bit per power domain, active low
  typedef logic [`EXT_DOMAINS-1:0] domain_t;

  // occupancy from 0 up to the full depth
  typedef logic [$clog2(`IFFIFO_DEPTH+1)-1:0] fifo_cnt_t;

  // decoded register-bus target
  typedef enum logic [1:0] {
    SEL_IFFIFO,
    SEL_POWER,
    SEL_NONE
  } periph_sel_t;

  // FIFO peripheral word offsets
  typedef enum logic [1:0] {
    REG_PUSH   = 2'd0,
    REG_POP    = 2'd1,
    REG_STATUS = 2'd2,
    REG_WMARK  = 2'd3
  } iffifo_reg_e;

endpackage

// ==== periph/ext_reg_demux.sv ====
/*
  routes register accesses by address to the FIFO or the power peripheral
  peripherals answer in the same cycle; a miss answers with error and zero data
*/
`include "ext_harness_defs.svh"

module ext_reg_demux (
  input  logic                   reg_valid_i,
  input  ext_harness_pkg::addr_t reg_addr_i,
  input  ext_harness_pkg::data_t iffifo_rdata_i,
  input  ext_harness_pkg::data_t pwr_rdata_i,
  output logic                   iffifo_valid_o,
  output logic                   pwr_valid_o,
  output logic                   reg_ready_o,
  output logic                   reg_error_o,
  output ext_harness_pkg::data_t reg_rdata_o
);

  import ext_harness_pkg::*;

  periph_sel_t sel;

  // addresses below the base wrap to large values and miss
  function automatic logic in_window(addr_t addr, addr_t base);
    addr_t rel;
    rel = addr - base;
    return rel < addr_t'(`PERIPH_WIN_SIZE);
  endfunction

  always_comb begin
    if (in_window(reg_addr_i, `IFFIFO_BASE)) begin
      sel = SEL_IFFIFO;
    end else if (in_window(reg_addr_i, `POWER_BASE)) begin
      sel = SEL_POWER;
    end else begin
      sel = SEL_NONE;
    end
  end

  assign iffifo_valid_o = reg_valid_i && (sel == SEL_IFFIFO);
  assign pwr_valid_o    = reg_valid_i && (sel == SEL_POWER);

  // no back-pressure
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i && (sel == SEL_NONE);

  always_comb begin
    case (sel)
      SEL_IFFIFO: reg_rdata_o = iffifo_rdata_i;
      SEL_POWER:  reg_rdata_o = pwr_rdata_i;
      default:    reg_rdata_o = '0;
    endcase
  end

endmodule

// ==== periph/iffifo.sv ====
/*
  register-mapped FIFO; pushes into a full FIFO are dropped, pops from empty read 0
  a read of the pop register is destructive; interrupt is off while the watermark is 0
*/
`include "ext_harness_defs.svh"

module iffifo (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        valid_i,
  input  logic                        write_i,
  input  ext_harness_pkg::iffifo_reg_e offset_i,
  input  ext_harness_pkg::data_t      wdata_i,
  output ext_harness_pkg::data_t      rdata_o,
  output logic                        intr_o,
  output logic                        slot_tx_o,
  output logic                        slot_rx_o
);

  import ext_harness_pkg::*;

  localparam int unsigned PTR_W = $clog2(`IFFIFO_DEPTH);
  localparam fifo_cnt_t FULL_CNT = fifo_cnt_t'(`IFFIFO_DEPTH);

  data_t            fifo_mem [`IFFIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  fifo_cnt_t        cnt_q;
  data_t            wmark_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (cnt_q == FULL_CNT);
  assign empty = (cnt_q == '0);
  assign push  = valid_i && write_i && (offset_i == REG_PUSH) && !full;
  assign pop   = valid_i && !write_i && (offset_i == REG_POP) && !empty;

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      wmark_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        cnt_q    <= cnt_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        cnt_q    <= cnt_q - 1'b1;
      end
      if (valid_i && write_i && offset_i == REG_WMARK) begin
        wmark_q <= wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= wdata_i;
    end
  end

  // push register reads back as 0
  always_comb begin
    case (offset_i)
      REG_POP:    rdata_o = empty ? '0 : fifo_mem[rd_ptr_q];
      REG_STATUS: rdata_o = data_t'(cnt_q);
      REG_WMARK:  rdata_o = wmark_q;
      default:    rdata_o = '0;
    endcase
  end

  assign intr_o    = (wmark_q != '0) && (data_t'(cnt_q) >= wmark_q);
  // DMA slots: room to push, data to pop
  assign slot_tx_o = !full;
  assign slot_rx_o = !empty;

endmodule

// ==== rtl/ext_harness_top.sv ====
/*
  register accesses complete in the cycle they are presented; windows alias inside
  memory addresses are byte addresses, only the word index bits reach the memory
*/
module ext_harness_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // register bus
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  ext_harness_pkg::addr_t reg_addr_i,
  input  ext_harness_pkg::data_t reg_wdata_i,
  output logic                   reg_ready_o,
  output logic                   reg_error_o,
  output ext_harness_pkg::data_t reg_rdata_o,
  // OBI memory port
  input  logic                   mem_req_i,
  input  logic                   mem_we_i,
  input  ext_harness_pkg::be_t   mem_be_i,
  input  ext_harness_pkg::addr_t mem_addr_i,
  input  ext_harness_pkg::data_t mem_wdata_i,
  output logic                   mem_gnt_o,
  output logic                   mem_rvalid_o,
  output ext_harness_pkg::data_t mem_rdata_o,
  // power switches
  output ext_harness_pkg::domain_t pwr_switch_n_o,
  output ext_harness_pkg::domain_t pwr_ack_n_o,
  // interrupt and DMA slots
  output logic                   iffifo_intr_o,
  output logic                   dma_slot_tx_o,
  output logic                   dma_slot_rx_o
);

  import ext_harness_pkg::*;

  logic     iffifo_valid;
  logic     pwr_valid;
  data_t    iffifo_rdata;
  data_t    pwr_rdata;

  // between request buffer and memory
  logic     fifo_mem_req;
  logic     fifo_mem_we;
  be_t      fifo_mem_be;
  mem_idx_t fifo_mem_idx;
  data_t    fifo_mem_wdata;
  logic     fifo_mem_gnt;
  logic     fifo_mem_rvalid;
  data_t    fifo_mem_rdata;

  ext_reg_demux reg_demux_i (
    .reg_valid_i   (reg_valid_i),
    .reg_addr_i    (reg_addr_i),
    .iffifo_rdata_i(iffifo_rdata),
    .pwr_rdata_i   (pwr_rdata),
    .iffifo_valid_o(iffifo_valid),
    .pwr_valid_o   (pwr_valid),
    .reg_ready_o   (reg_ready_o),
    .reg_error_o   (reg_error_o),
    .reg_rdata_o   (reg_rdata_o)
  );

  // word offset is the address above the byte bits
  iffifo iffifo_i (
    .clk_i,
    .rst_n_i,
    .valid_i  (iffifo_valid),
    .write_i  (reg_write_i),
    .offset_i (iffifo_reg_e'(reg_addr_i[3:2])),
    .wdata_i  (reg_wdata_i),
    .rdata_o  (iffifo_rdata),
    .intr_o   (iffifo_intr_o),
    .slot_tx_o(dma_slot_tx_o),
    .slot_rx_o(dma_slot_rx_o)
  );

  power_switch_ctrl power_switch_ctrl_i (
    .clk_i,
    .rst_n_i,
    .valid_i   (pwr_valid),
    .write_i   (reg_write_i),
    .offset_i  (reg_addr_i[2]),
    .wdata_i   (reg_wdata_i),
    .rdata_o   (pwr_rdata),
    .switch_n_o(pwr_switch_n_o),
    .ack_n_o   (pwr_ack_n_o)
  );

  // extra buffer stage in front of the slow memory
  obi_fifo obi_fifo_i (
    .clk_i,
    .rst_n_i,
    .req_i       (mem_req_i),
    .we_i        (mem_we_i),
    .be_i        (mem_be_i),
    .addr_i      (mem_addr_i),
    .wdata_i     (mem_wdata_i),
    .gnt_o       (mem_gnt_o),
    .rvalid_o    (mem_rvalid_o),
    .rdata_o     (mem_rdata_o),
    .mem_req_o   (fifo_mem_req),
    .mem_we_o    (fifo_mem_we),
    .mem_be_o    (fifo_mem_be),
    .mem_idx_o   (fifo_mem_idx),
    .mem_wdata_o (fifo_mem_wdata),
    .mem_gnt_i   (fifo_mem_gnt),
    .mem_rvalid_i(fifo_mem_rvalid),
    .mem_rdata_i (fifo_mem_rdata)
  );

  slow_memory slow_ram_i (
    .clk_i,
    .rst_n_i,
    .req_i   (fifo_mem_req),
    .we_i    (fifo_mem_we),
    .be_i    (fifo_mem_be),
    .idx_i   (fifo_mem_idx),
    .wdata_i (fifo_mem_wdata),
    .gnt_o   (fifo_mem_gnt),
    .rvalid_o(fifo_mem_rvalid),
    .rdata_o (fifo_mem_rdata)
  );

endmodule

// ==== rtl/power_switch_ctrl.sv ====
/*
  switch-off register and emulated switch cells, active low per domain
  SWITCH_ACK_LATENCY must be at least 1; writes to the ack offset are ignored
*/
`include "ext_harness_defs.svh"

module power_switch_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic                     write_i,
  input  logic                     offset_i,
  input  ext_harness_pkg::data_t   wdata_i,
  output ext_harness_pkg::data_t   rdata_o,
  output ext_harness_pkg::domain_t switch_n_o,
  output ext_harness_pkg::domain_t ack_n_o
);

  import ext_harness_pkg::*;

  localparam int unsigned LAT = `SWITCH_ACK_LATENCY;

  domain_t switch_n_q;
  // switch cells, one stage per cycle of acknowledge delay
  domain_t ack_chain_q [LAT];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      switch_n_q <= '1;
      for (int i = 0; i < LAT; i++) begin
        ack_chain_q[i] <= '1;
      end
    end else begin
      if (valid_i && write_i && offset_i == `PWR_SWITCH_OFF) begin
        switch_n_q <= wdata_i[`EXT_DOMAINS-1:0];
      end
      ack_chain_q[0] <= switch_n_q;
      for (int i = 1; i < LAT; i++) begin
        ack_chain_q[i] <= ack_chain_q[i-1];
      end
    end
  end

  assign switch_n_o = switch_n_q;
  assign ack_n_o    = ack_chain_q[LAT-1];

  assign rdata_o = (offset_i == `PWR_ACK_OFF) ? data_t'(ack_n_o) : data_t'(switch_n_q);

endmodule

// ==== slow_mem/obi_fifo.sv ====
/*
  OBI request buffer in front of the slow memory; grants a request whenever not full
  responses pass straight through, so downstream must answer in request order
*/
`include "ext_harness_defs.svh"

module obi_fifo (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // upstream
  input  logic                     req_i,
  input  logic                     we_i,
  input  ext_harness_pkg::be_t     be_i,
  input  ext_harness_pkg::addr_t   addr_i,
  input  ext_harness_pkg::data_t   wdata_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output ext_harness_pkg::data_t   rdata_o,
  // downstream
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output ext_harness_pkg::be_t     mem_be_o,
  output ext_harness_pkg::mem_idx_t mem_idx_o,
  output ext_harness_pkg::data_t   mem_wdata_o,
  input  logic                     mem_gnt_i,
  input  logic                     mem_rvalid_i,
  input  ext_harness_pkg::data_t   mem_rdata_i
);

  import ext_harness_pkg::*;

  localparam int unsigned DEPTH = `OBI_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // request payload, no reset
  logic     we_q    [DEPTH];
  be_t      be_q    [DEPTH];
  mem_idx_t idx_q   [DEPTH];
  data_t    wdata_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             accept;
  logic             issue;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // grant only a presented request
  assign gnt_o  = req_i && (cnt_q != CNT_W'(DEPTH));
  assign accept = gnt_o;
  assign issue  = mem_req_o && mem_gnt_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (accept) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (issue) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (accept && !issue) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (issue && !accept) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q[wr_ptr_q]    <= we_i;
      be_q[wr_ptr_q]    <= be_i;
      // byte address to word index
      idx_q[wr_ptr_q]   <= addr_i[2 +: $bits(mem_idx_t)];
      wdata_q[wr_ptr_q] <= wdata_i;
    end
  end

  // head entry goes downstream
  assign mem_req_o   = (cnt_q != '0);
  assign mem_we_o    = we_q[rd_ptr_q];
  assign mem_be_o    = be_q[rd_ptr_q];
  assign mem_idx_o   = idx_q[rd_ptr_q];
  assign mem_wdata_o = wdata_q[rd_ptr_q];

  assign rvalid_o = mem_rvalid_i;
  assign rdata_o  = mem_rdata_i;

endmodule

// ==== slow_mem/slow_memory.sv ====
/*
  word memory granting each request SLOW_MEM_GNT_WAIT cycles after it appears
  rvalid follows the grant by one cycle; writes answer with rdata 0; contents not reset
*/
`include "ext_harness_defs.svh"

module slow_memory (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  ext_harness_pkg::be_t      be_i,
  input  ext_harness_pkg::mem_idx_t idx_i,
  input  ext_harness_pkg::data_t    wdata_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output ext_harness_pkg::data_t    rdata_o
);

  import ext_harness_pkg::*;

  localparam int unsigned CNT_W = $clog2(`SLOW_MEM_GNT_WAIT + 1);
  localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(`SLOW_MEM_GNT_WAIT);

  data_t            mem_q [`SLOW_MEM_WORDS];
  logic [CNT_W-1:0] wait_q;
  logic             rvalid_q;
  data_t            rdata_q;

  assign gnt_o = req_i && (wait_q == WAIT_LAST);

  // wait count restarts for every presented request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
      if (req_i && !gnt_o) begin
        wait_q <= wait_q + 1'b1;
      end else begin
        wait_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int b = 0; b < `EXT_BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[idx_i];
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== verilog.f ====
+incdir+common
common/ext_harness_pkg.sv
periph/ext_reg_demux.sv
periph/iffifo.sv
rtl/power_switch_ctrl.sv
slow_mem/obi_fifo.sv
slow_mem/slow_memory.sv
rtl/ext_harness_top.sv
bench/tb_ext_harness.sv
